// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  exec_pkg::funct_e            funct,
  input  logic [4:0]                  shamt,
  input  logic [exec_pkg::data_w-1:0] operand_1,
  input  logic [exec_pkg::data_w-1:0] operand_2,
  output logic [exec_pkg::data_w-1:0] result,
  output logic                        overflow
);

  localparam int msb = exec_pkg::data_w - 1;

  logic            is_sub;
  logic            is_ovf_op;
  logic [msb:0]    op2_mux;
  logic [msb:0]    sum;
  logic            signed_lt;
  logic            unsigned_lt;

  // subtract and compare share the adder
  assign is_sub = (funct == exec_pkg::funct_sub)  ||
                  (funct == exec_pkg::funct_subu) ||
                  (funct == exec_pkg::funct_slt)  ||
                  (funct == exec_pkg::funct_sltu);

  assign is_ovf_op = (funct == exec_pkg::funct_add) ||
                     (funct == exec_pkg::funct_sub);

  // two's complement: invert and carry in one
  assign op2_mux = is_sub ? ~operand_2 : operand_2;
  assign sum     = operand_1 + op2_mux + {{msb{1'b0}}, is_sub};

  // same sign in, other sign out
  assign overflow = is_ovf_op &&
                    (operand_1[msb] == op2_mux[msb]) &&
                    (sum[msb] != operand_1[msb]);

  // negative vs positive, or same sign and negative difference
  assign signed_lt = (operand_1[msb] && !operand_2[msb]) ||
                     ((operand_1[msb] == operand_2[msb]) && sum[msb]);

  assign unsigned_lt = operand_1 < operand_2;

  always_comb begin
    case (funct)
      exec_pkg::funct_add,
      exec_pkg::funct_addu,
      exec_pkg::funct_sub,
      exec_pkg::funct_subu: begin
        result = sum;
      end
      exec_pkg::funct_and: begin
        result = operand_1 & operand_2;
      end
      exec_pkg::funct_or: begin
        result = operand_1 | operand_2;
      end
      exec_pkg::funct_xor: begin
        result = operand_1 ^ operand_2;
      end
      exec_pkg::funct_slt: begin
        result = {{msb{1'b0}}, signed_lt};
      end
      exec_pkg::funct_sltu: begin
        result = {{msb{1'b0}}, unsigned_lt};
      end
      exec_pkg::funct_sll: begin
        result = operand_2 << shamt;
      end
      exec_pkg::funct_sllv: begin
        result = operand_2 << operand_1[4:0];
      end
      exec_pkg::funct_srlv: begin
        result = operand_2 >> operand_1[4:0];
      end
      exec_pkg::funct_srav: begin
        // sign filled
        result = $signed(operand_2) >>> operand_1[4:0];
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int RAM_DEPTH = 256
) (
  input  logic                         clk,
  input  logic                         en,
  input  logic [3:0]                   we,
  input  logic [$clog2(RAM_DEPTH)-1:0] addr,
  input  logic [exec_pkg::data_w-1:0]  wdata,
  output logic [exec_pkg::data_w-1:0]  rdata
);

  // byte addressable storage
  logic [3:0][7:0] mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (we[lane]) begin
          mem[addr][lane] <= wdata[lane*8 +: 8];
        end
      end
      // read returns the old word on a write
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic              clk,
  input  logic              rst,
  input  exec_pkg::ex_req_t req,
  output logic              ex_load_flag,
  output exec_pkg::ex_mem_t ex_mem
);

  logic [exec_pkg::data_w-1:0] alu_result;
  logic                        alu_overflow;
  logic [exec_pkg::data_w-1:0] hi;
  logic [exec_pkg::data_w-1:0] lo;
  logic                        is_mul;
  exec_pkg::ex_mem_t           ex_next;

  alu u_alu (
    .funct     (req.funct),
    .shamt     (req.shamt),
    .operand_1 (req.operand_1),
    .operand_2 (req.operand_2),
    .result    (alu_result),
    .overflow  (alu_overflow)
  );

  mul_hilo u_mul_hilo (
    .clk       (clk),
    .rst       (rst),
    .funct     (req.funct),
    .valid     (req.valid),
    .operand_1 (req.operand_1),
    .operand_2 (req.operand_2),
    .hi        (hi),
    .lo        (lo)
  );

  // lets ID stall on a load-use hazard
  assign ex_load_flag = req.valid && req.mem_ctrl.read;

  assign is_mul = (req.funct == exec_pkg::funct_mult) ||
                  (req.funct == exec_pkg::funct_multu);

  always_comb begin
    ex_next.valid          = req.valid;
    ex_next.overflow       = alu_overflow;
    ex_next.mem_ctrl       = req.mem_ctrl;
    ex_next.mem_write_data = req.mem_write_data;
    ex_next.reg_write_addr = req.reg_write_addr;
    ex_next.pc             = req.pc;
    case (req.funct)
      exec_pkg::funct_mfhi: ex_next.result = hi;
      exec_pkg::funct_mflo: ex_next.result = lo;
      default:              ex_next.result = alu_result;
    endcase
    // stores, overflow and multiplies leave the register file alone
    ex_next.reg_write_en = req.valid && req.reg_write_en && !req.mem_ctrl.write &&
                           !alu_overflow && !is_mul;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem.valid          <= 1'b0;
      ex_mem.reg_write_en   <= 1'b0;
      ex_mem.mem_ctrl.read  <= 1'b0;
      ex_mem.mem_ctrl.write <= 1'b0;
    end else begin
      ex_mem <= ex_next;
    end
  end

endmodule

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;

  // funct codes of the R-type instructions handled in EX
  typedef enum logic [5:0] {
    funct_sll   = 6'h00,
    funct_sllv  = 6'h04,
    funct_srlv  = 6'h06,
    funct_srav  = 6'h07,
    funct_mfhi  = 6'h10,
    funct_mflo  = 6'h12,
    funct_mult  = 6'h18,
    funct_multu = 6'h19,
    funct_add   = 6'h20,
    funct_addu  = 6'h21,
    funct_sub   = 6'h22,
    funct_subu  = 6'h23,
    funct_and   = 6'h24,
    funct_or    = 6'h25,
    funct_xor   = 6'h26,
    funct_slt   = 6'h2a,
    funct_sltu  = 6'h2b
  } funct_e;

  typedef enum logic [1:0] {
    mem_byte = 2'd0,
    mem_half = 2'd1,
    mem_word = 2'd2
  } mem_size_e;

  typedef struct packed {
    logic      read;
    logic      write;
    logic      sign_ext;
    mem_size_e size;
  } mem_ctrl_t;

  // decoded instruction as delivered by ID
  typedef struct packed {
    logic                  valid;
    funct_e                funct;
    logic [4:0]            shamt;
    logic [data_w-1:0]     operand_1;
    logic [data_w-1:0]     operand_2;
    mem_ctrl_t             mem_ctrl;
    logic [data_w-1:0]     mem_write_data;
    logic                  reg_write_en;
    logic [reg_addr_w-1:0] reg_write_addr;
    logic [data_w-1:0]     pc;
  } ex_req_t;

  // result doubles as the memory address
  typedef struct packed {
    logic                  valid;
    logic [data_w-1:0]     result;
    logic                  overflow;
    mem_ctrl_t             mem_ctrl;
    logic [data_w-1:0]     mem_write_data;
    logic                  reg_write_en;
    logic [reg_addr_w-1:0] reg_write_addr;
    logic [data_w-1:0]     pc;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic                  reg_write_en;
    logic [reg_addr_w-1:0] reg_write_addr;
    logic [data_w-1:0]     data;
    logic                  overflow;
    logic [data_w-1:0]     pc;
  } wb_t;

  // one data word by byte lane or by halfword lane
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage

`default_nettype wire

// ==== exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter int RAM_DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  exec_pkg::ex_req_t req,
  output logic              ex_load_flag,
  output exec_pkg::wb_t     wb
);

  // EX/MEM pipeline register contents
  exec_pkg::ex_mem_t ex_mem;

  ex_stage u_ex_stage (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ex_load_flag (ex_load_flag),
    .ex_mem       (ex_mem)
  );

  mem_stage #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_mem_stage (
    .clk    (clk),
    .rst    (rst),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
  parameter int RAM_DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  exec_pkg::ex_mem_t ex_mem,
  output exec_pkg::wb_t     wb
);

  localparam int addr_w = $clog2(RAM_DEPTH);

  logic [addr_w-1:0]           ram_addr;
  logic [1:0]                  offset;
  logic                        ram_en;
  logic [3:0]                  ram_we;
  logic [3:0]                  lane_be;
  exec_pkg::mem_word_u         store_word;
  logic [exec_pkg::data_w-1:0] ram_rdata;
  exec_pkg::mem_word_u         load_word;
  logic [exec_pkg::data_w-1:0] load_data;
  exec_pkg::wb_t               wb_q;
  logic                        load_q;
  logic [1:0]                  offset_q;
  exec_pkg::mem_size_e         size_q;
  logic                        sign_q;

  assign ram_addr = ex_mem.result[addr_w+1:2];
  assign offset   = ex_mem.result[1:0];

  // store lanes, data repeated so any enabled lane sees it
  always_comb begin
    store_word = '0;
    lane_be    = 4'b0000;
    case (ex_mem.mem_ctrl.size)
      exec_pkg::mem_byte: begin
        store_word.bytes = {4{ex_mem.mem_write_data[7:0]}};
        lane_be[offset]  = 1'b1;
      end
      exec_pkg::mem_half: begin
        store_word.halves = {2{ex_mem.mem_write_data[15:0]}};
        lane_be           = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_word.halves = ex_mem.mem_write_data;
        lane_be           = 4'b1111;
      end
    endcase
  end

  assign ram_en = ex_mem.valid && (ex_mem.mem_ctrl.read || ex_mem.mem_ctrl.write);
  assign ram_we = (ex_mem.valid && ex_mem.mem_ctrl.write) ? lane_be : 4'b0000;

  data_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_data_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (store_word),
    .rdata (ram_rdata)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q.valid        <= 1'b0;
      wb_q.reg_write_en <= 1'b0;
      load_q            <= 1'b0;
    end else begin
      wb_q.valid          <= ex_mem.valid;
      wb_q.reg_write_en   <= ex_mem.reg_write_en;
      wb_q.reg_write_addr <= ex_mem.reg_write_addr;
      wb_q.data           <= ex_mem.result;
      wb_q.overflow       <= ex_mem.overflow;
      wb_q.pc             <= ex_mem.pc;
      load_q              <= ex_mem.valid && ex_mem.mem_ctrl.read;
      offset_q            <= offset;
      size_q              <= ex_mem.mem_ctrl.size;
      sign_q              <= ex_mem.mem_ctrl.sign_ext;
    end
  end

  // pick the lane out of the word the RAM just returned
  always_comb begin
    load_word = ram_rdata;
    case (size_q)
      exec_pkg::mem_byte: begin
        load_data = {{24{sign_q && load_word.bytes[offset_q][7]}},
                     load_word.bytes[offset_q]};
      end
      exec_pkg::mem_half: begin
        load_data = {{16{sign_q && load_word.halves[offset_q[1]][15]}},
                     load_word.halves[offset_q[1]]};
      end
      default: begin
        load_data = ram_rdata;
      end
    endcase
  end

  always_comb begin
    wb = wb_q;
    if (load_q) begin
      wb.data = load_data;
    end
  end

endmodule

`default_nettype wire

// ==== mul_hilo.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_hilo (
  input  logic                        clk,
  input  logic                        rst,
  input  exec_pkg::funct_e            funct,
  input  logic                        valid,
  input  logic [exec_pkg::data_w-1:0] operand_1,
  input  logic [exec_pkg::data_w-1:0] operand_2,
  output logic [exec_pkg::data_w-1:0] hi,
  output logic [exec_pkg::data_w-1:0] lo
);

  localparam int msb = exec_pkg::data_w - 1;

  logic                             is_mult;
  logic                             is_multu;
  logic [msb:0]                     mag_1;
  logic [msb:0]                     mag_2;
  logic [2*exec_pkg::data_w-1:0]    mag_prod;
  logic                             negate;
  logic [2*exec_pkg::data_w-1:0]    product;

  assign is_mult  = (funct == exec_pkg::funct_mult);
  assign is_multu = (funct == exec_pkg::funct_multu);

  // signed: multiply magnitudes, fix sign afterwards
  assign mag_1 = (is_mult && operand_1[msb]) ? -operand_1 : operand_1;
  assign mag_2 = (is_mult && operand_2[msb]) ? -operand_2 : operand_2;

  assign mag_prod = mag_1 * mag_2;

  assign negate  = is_mult && (operand_1[msb] ^ operand_2[msb]);
  assign product = negate ? -mag_prod : mag_prod;

  always_ff @(posedge clk) begin
    if (rst) begin
      hi <= '0;
      lo <= '0;
    end else if (valid && (is_mult || is_multu)) begin
      hi <= product[2*exec_pkg::data_w-1:exec_pkg::data_w];
      lo <= product[msb:0];
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_exec -f src.f -o tb_exec_sim
./obj_dir/tb_exec_sim > sim.log 2>&1
cat sim.log
if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Test OK" sim.log; then
  exit 1
fi

// ==== src.f ====
exec_pkg.sv
alu.sv
mul_hilo.sv
ex_stage.sv
data_ram.sv
mem_stage.sv
exec_top.sv
tb_exec.sv

// ==== tb_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec;

  // the tests take roughly 1500 cycles
  localparam int run_cycles     = 1500;
  localparam int timeout_cycles = 2 * run_cycles;

  logic              clk;
  logic              rst;
  exec_pkg::ex_req_t req;
  logic              load_flag;
  exec_pkg::wb_t     wb;
  exec_pkg::wb_t     exp_q [$];
  logic [31:0]       seed = 32'h93ec;
  logic [31:0]       hi_m;
  logic [31:0]       lo_m;
  logic [31:0]       pc_m;
  logic [7:0]        shadow [1024];
  int                cycle_cnt = 0;
  int                err_cnt;
  int                tests_passed;
  int                tests_failed;

  exec_top #(
    .RAM_DEPTH (256)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ex_load_flag (load_flag),
    .wb           (wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("timeout: the run did not end within %0d cycles", timeout_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // reference ALU, straight from the instruction definitions
  function automatic logic [31:0] alu_ref(input exec_pkg::funct_e f, input logic [4:0] sh,
                                          input logic [31:0] a, input logic [31:0] b,
                                          output logic ovf);
    logic [32:0] wide;
    logic [63:0] sra;
    wide = '0;
    if (f == exec_pkg::funct_add) wide = {a[31], a} + {b[31], b};
    if (f == exec_pkg::funct_sub) wide = {a[31], a} - {b[31], b};
    // 33-bit signed result that does not fit in 32 bits
    ovf = wide[32] != wide[31];
    sra = {{32{b[31]}}, b} >> a[4:0];
    case (f)
      exec_pkg::funct_add, exec_pkg::funct_addu: return a + b;
      exec_pkg::funct_sub, exec_pkg::funct_subu: return a - b;
      exec_pkg::funct_and:  return a & b;
      exec_pkg::funct_or:   return a | b;
      exec_pkg::funct_xor:  return a ^ b;
      exec_pkg::funct_slt:  return {31'd0, $signed(a) < $signed(b)};
      exec_pkg::funct_sltu: return {31'd0, a < b};
      exec_pkg::funct_sll:  return b << sh;
      exec_pkg::funct_sllv: return b << a[4:0];
      exec_pkg::funct_srlv: return b >> a[4:0];
      exec_pkg::funct_srav: return sra[31:0];
      default:              return '0;
    endcase
  endfunction

  // little endian with the low address bits beyond the size dropped
  task automatic store_ref(input logic [9:0] addr, input exec_pkg::mem_size_e size,
                           input logic [31:0] data);
    int n;
    n = 1 << size;
    for (int i = 0; i < n; i++) shadow[(addr & ~10'(n - 1)) + 10'(i)] = data[8*i +: 8];
  endtask

  function automatic logic [31:0] load_ref(input logic [9:0] addr,
                                           input exec_pkg::mem_size_e size, input logic sx);
    int          n;
    logic [31:0] val;
    n   = 1 << size;
    val = '0;
    for (int i = 0; i < n; i++) val[8*i +: 8] = shadow[(addr & ~10'(n - 1)) + 10'(i)];
    if (sx && val[8*n-1]) val = val | (32'hffff_ffff << (8 * n));
    return val;
  endfunction

  function automatic exec_pkg::mem_ctrl_t mem_access(input logic rd, input logic wr,
                                                     input logic sx,
                                                     input exec_pkg::mem_size_e size);
    return '{rd, wr, sx, size};
  endfunction

  task automatic check_wb(input exec_pkg::wb_t exp, input exec_pkg::wb_t act, input string what);
    // a bubble only has to keep valid low
    if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s pc %h, expected %h, got %h",
               $time, what, exp.pc, exp, act);
    end
  endtask

  task automatic check_flag(input logic exp, input logic act, input string what);
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, what, exp, act);
    end
  endtask

  // check what was issued two cycles ago, then drive the next request
  task automatic step(input exec_pkg::ex_req_t r, input exec_pkg::wb_t e);
    @(negedge clk);
    if (exp_q.size() == 2) check_wb(exp_q.pop_front(), wb, "writeback");
    req = r;
    exp_q.push_back(e);
    #1;
    check_flag(r.valid && r.mem_ctrl.read, load_flag, "load flag");
  endtask

  task automatic bubble();
    step('0, '0);
  endtask

  task automatic issue(input exec_pkg::funct_e funct, input logic [4:0] shamt,
                       input logic [31:0] a, input logic [31:0] b,
                       input exec_pkg::mem_ctrl_t mc, input logic [31:0] wdata);
    exec_pkg::ex_req_t r;
    exec_pkg::wb_t     e;
    logic              ovf;
    logic              is_mul;
    logic [63:0]       prod;
    logic [31:0]       res;
    res    = alu_ref(funct, shamt, a, b, ovf);
    is_mul = (funct == exec_pkg::funct_mult) || (funct == exec_pkg::funct_multu);
    if (funct == exec_pkg::funct_mfhi) res = hi_m;
    if (funct == exec_pkg::funct_mflo) res = lo_m;
    if (funct == exec_pkg::funct_mult) begin
      // low 64 bits of the sign extended operands give the signed product
      prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    end else begin
      prod = {32'd0, a} * {32'd0, b};
    end
    if (is_mul) {hi_m, lo_m} = prod;
    if (mc.write) store_ref(res[9:0], mc.size, wdata);
    if (mc.read) res = load_ref(res[9:0], mc.size, mc.sign_ext);
    r = '{1'b1, funct, shamt, a, b, mc, wdata, 1'b1, pc_m[6:2], pc_m};
    e = '{1'b1, !mc.write && !ovf && !is_mul, pc_m[6:2], res, ovf, pc_m};
    pc_m = pc_m + 32'd4;
    step(r, e);
  endtask

  task automatic report_test(input string name, input int errs_before);
    bubble();
    bubble();
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic test_flag_bubbles();
    int errs;
    errs = err_cnt;
    // wb stays idle out of reset
    repeat (4) bubble();
    issue(exec_pkg::funct_addu, 5'd0, 32'd1, 32'd2, '0, 32'd0);
    repeat (3) bubble();
    issue(exec_pkg::funct_addu, 5'd0, 32'h120, 32'd0, mem_access(0, 1, 0, exec_pkg::mem_word),
          next_random());
    issue(exec_pkg::funct_addu, 5'd0, 32'h120, 32'd0, mem_access(1, 0, 0, exec_pkg::mem_word),
          32'd0);
    issue(exec_pkg::funct_or, 5'd0, 32'd3, 32'd4, '0, 32'd0);
    report_test("load flag and bubbles", errs);
  endtask

  task automatic test_alu_ops();
    exec_pkg::funct_e ops [7];
    int               errs;
    logic [31:0]      a;
    errs = err_cnt;
    ops  = '{exec_pkg::funct_addu, exec_pkg::funct_subu, exec_pkg::funct_and,
             exec_pkg::funct_or, exec_pkg::funct_xor, exec_pkg::funct_slt,
             exec_pkg::funct_sltu};
    for (int i = 0; i < 7; i++) begin
      for (int k = 0; k < 120; k++) begin
        a = next_random();
        // equal operands now and then for the compares
        issue(ops[i], 5'd0, a, (k % 10 == 0) ? a : next_random(), '0, 32'd0);
      end
    end
    report_test("alu ops", errs);
  endtask

  task automatic test_shifts();
    exec_pkg::funct_e ops [4];
    int               errs;
    logic [31:0]      r;
    logic [31:0]      b;
    logic [4:0]       amt;
    errs = err_cnt;
    ops  = '{exec_pkg::funct_sll, exec_pkg::funct_sllv, exec_pkg::funct_srlv,
             exec_pkg::funct_srav};
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 50; k++) begin
        r   = next_random();
        amt = (k == 0) ? 5'd0 : (k == 1) ? 5'd31 : r[4:0];
        b   = next_random();
        if (k % 2 == 1) b[31] = 1'b1;
        // the amount field the op ignores never matches the real amount
        issue(ops[i], (ops[i] == exec_pkg::funct_sll) ? amt : ~amt,
              {r[31:5], (ops[i] == exec_pkg::funct_sll) ? ~amt : amt}, b, '0, 32'd0);
      end
    end
    report_test("shifts", errs);
  endtask

  task automatic test_multiply();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = err_cnt;
    for (int k = 0; k < 24; k++) begin
      a = next_random();
      b = next_random();
      // both negative, mixed signs, then plain random
      a[31] = (k % 3 != 2) ? 1'b1 : a[31];
      b[31] = (k % 3 == 0) ? 1'b1 : (k % 3 == 1) ? 1'b0 : b[31];
      issue((k % 2 == 1) ? exec_pkg::funct_multu : exec_pkg::funct_mult, 5'd0, a, b, '0, 32'd0);
      issue(exec_pkg::funct_mfhi, 5'd0, 32'd0, 32'd0, '0, 32'd0);
      issue(exec_pkg::funct_mflo, 5'd0, 32'd0, 32'd0, '0, 32'd0);
    end
    report_test("multiply", errs);
  endtask

  task automatic test_load_store();
    int errs;
    errs = err_cnt;
    // words over 0x100..0x11f first, then bytes and halves on top
    for (int k = 0; k < 8; k++) begin
      issue(exec_pkg::funct_addu, 5'd0, 32'h100, 32'(4 * k),
            mem_access(0, 1, 0, exec_pkg::mem_word), next_random());
    end
    for (int k = 0; k < 8; k++) begin
      issue(exec_pkg::funct_addu, 5'd0, 32'h100, 32'(3 * k),
            mem_access(0, 1, 0, exec_pkg::mem_byte), next_random());
      issue(exec_pkg::funct_addu, 5'd0, 32'h108, 32'(2 * k + 1),
            mem_access(0, 1, 0, exec_pkg::mem_half), next_random());
    end
    for (int off = 0; off < 32; off++) begin
      for (int s = 0; s < 5; s++) begin
        issue(exec_pkg::funct_addu, 5'd0, 32'h100, 32'(off),
              mem_access(1, 0, s[0], (s < 2) ? exec_pkg::mem_byte :
                         (s < 4) ? exec_pkg::mem_half : exec_pkg::mem_word), 32'd0);
      end
    end
    report_test("loads and stores", errs);
  endtask

  task automatic test_overflow();
    int          errs;
    logic [31:0] ov_a [6];
    logic [31:0] ov_b [6];
    errs = err_cnt;
    ov_a = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0005,
             32'h8000_0000, 32'h7fff_ffff, 32'h0000_000a};
    ov_b = '{32'h0000_0001, 32'h8000_0000, 32'hffff_fffd,
             32'h0000_0001, 32'hffff_ffff, 32'h0000_0003};
    for (int i = 0; i < 6; i++) begin
      issue((i < 3) ? exec_pkg::funct_add : exec_pkg::funct_sub, 5'd0, ov_a[i], ov_b[i],
            '0, 32'd0);
      issue((i < 3) ? exec_pkg::funct_addu : exec_pkg::funct_subu, 5'd0, ov_a[i], ov_b[i],
            '0, 32'd0);
    end
    for (int k = 0; k < 40; k++) begin
      issue((k % 2 == 1) ? exec_pkg::funct_sub : exec_pkg::funct_add, 5'd0, next_random(),
            next_random(), '0, 32'd0);
    end
    report_test("overflow", errs);
  endtask

  initial begin
    rst          = 1'b1;
    req          = '0;
    hi_m         = '0;
    lo_m         = '0;
    pc_m         = '0;
    err_cnt      = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_flag_bubbles();
    test_alu_ops();
    test_shifts();
    test_multiply();
    test_load_store();
    test_overflow();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
